// File: common/core_pkg.sv
`default_nettype none

package core_pkg;

    // Core sizes
    localparam int IMEM_ADDR_W = 10;
    localparam int RF_ADDR_W   = 5;
    localparam int DATA_W      = 32;
    localparam int NET_ID_W    = 10;

    // Network ID this core answers to
    localparam logic [NET_ID_W-1:0] CORE_ID = 10'd1;

    // Instruction opcodes, NOP must stay at zero
    typedef enum logic [5:0] {
        NOP, ADDU, SUBU, AND, OR, SLT, MOV,
        BEQZ, BNEQZ, JALR, SW, WAIT
    } opcode_e;

    // rs_imm is a source register, or a signed offset for branches
    typedef struct packed {
        opcode_e                opcode;
        logic [RF_ADDR_W-1:0]   rd;
        logic [RF_ADDR_W-1:0]   rs_imm;
    } instr_t;

    localparam instr_t INSTR_NOP = '{opcode: NOP, rd: '0, rs_imm: '0};

    // Network commands
    typedef enum logic [1:0] {
        NET_NULL, NET_INSTR, NET_REG, NET_PC
    } net_op_e;

    typedef struct packed {
        logic [NET_ID_W-1:0]    id;
        net_op_e                op;
        logic [IMEM_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]      data;
    } net_packet_t;

    // Write-only store port, one strobe per store
    typedef struct packed {
        logic               valid;
        logic [DATA_W-1:0]  addr;
        logic [DATA_W-1:0]  data;
    } store_t;

    typedef enum logic [1:0] {
        IDLE, RUN, ERR
    } run_state_e;

    // Decoded network strobes plus run and stall
    typedef struct packed {
        logic                   imem_wr;
        logic                   rf_wr;
        logic                   pc_load;
        logic                   run;
        logic                   stall;
        logic [RF_ADDR_W-1:0]   rf_addr;
        logic [IMEM_ADDR_W-1:0] pc_addr;
    } ctrl_t;

endpackage

`default_nettype wire

// File: pipeline/exec_stage.sv
`timescale 1ns/10ps
`default_nettype none

module exec_stage
(
    input  wire                                 clk,
    input  wire                                 n_reset,
    input  wire core_pkg::ctrl_t                ctrl_i,
    input  wire core_pkg::net_packet_t          net_packet_i,
    input  wire core_pkg::instr_t               if_instr_i,
    input  wire logic [core_pkg::IMEM_ADDR_W-1:0] if_pc_i,
    output logic                                redirect_o,
    output logic [core_pkg::IMEM_ADDR_W-1:0]    redirect_pc_o,
    output logic                                halt_o,
    output logic                                rf_busy_o,
    output core_pkg::store_t                    store_o
);
    import core_pkg::*;

    instr_t                 ex_instr;
    logic [IMEM_ADDR_W-1:0] ex_pc;
    logic [DATA_W-1:0]      ex_rs;
    logic [DATA_W-1:0]      ex_rd;
    logic [DATA_W-1:0]      rs_val;
    logic [DATA_W-1:0]      rd_val;
    logic [DATA_W-1:0]      rs_fwd;
    logic [DATA_W-1:0]      rd_fwd;
    logic                   rf_wr_en;
    logic [RF_ADDR_W-1:0]   rf_wr_addr;
    logic [DATA_W-1:0]      rf_wr_data;
    logic [DATA_W-1:0]      alu_result;
    logic [IMEM_ADDR_W-1:0] pc_plus1;
    logic [IMEM_ADDR_W-1:0] branch_pc;
    logic                   advance;
    logic                   writes_rf;
    logic                   taken;
    logic                   store_valid_q;
    logic [DATA_W-1:0]      store_addr_q;
    logic [DATA_W-1:0]      store_data_q;

    assign advance = ctrl_i.run & ~ctrl_i.stall;

    reg_file u_rf (
        .clk       (clk),
        .rs_addr_i (if_instr_i.rs_imm),
        .rd_addr_i (if_instr_i.rd),
        .wr_en_i   (rf_wr_en),
        .wr_addr_i (rf_wr_addr),
        .wr_data_i (rf_wr_data),
        .rs_val_o  (rs_val),
        .rd_val_o  (rd_val)
    );

    // Network write owns the port, execute write waits via stall
    assign rf_wr_en   = ctrl_i.rf_wr | (writes_rf & advance);
    assign rf_wr_addr = ctrl_i.rf_wr ? ctrl_i.rf_addr : ex_instr.rd;
    assign rf_wr_data = ctrl_i.rf_wr ? net_packet_i.data : alu_result;

    // Bypass the value being written into decode
    assign rs_fwd = (rf_wr_en && (rf_wr_addr == if_instr_i.rs_imm) && (if_instr_i.rs_imm != '0))
                    ? rf_wr_data : rs_val;
    assign rd_fwd = (rf_wr_en && (rf_wr_addr == if_instr_i.rd) && (if_instr_i.rd != '0))
                    ? rf_wr_data : rd_val;

    // Decode/execute register, flushed on redirect
    always_ff @(posedge clk)
    begin
        if (!n_reset)
            ex_instr <= INSTR_NOP;
        else if (advance)
            ex_instr <= redirect_o ? INSTR_NOP : if_instr_i;
    end

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            ex_pc <= if_pc_i;
            ex_rs <= rs_fwd;
            ex_rd <= rd_fwd;
        end
    end

    // ALU, rd is the first operand
    assign pc_plus1 = ex_pc + 1'b1;
    always_comb
    begin
        case (ex_instr.opcode)
            ADDU:    alu_result = ex_rd + ex_rs;
            SUBU:    alu_result = ex_rd - ex_rs;
            AND:     alu_result = ex_rd & ex_rs;
            OR:      alu_result = ex_rd | ex_rs;
            SLT:     alu_result = DATA_W'($signed(ex_rd) < $signed(ex_rs));
            MOV:     alu_result = ex_rs;
            JALR:    alu_result = DATA_W'(pc_plus1);
            default: alu_result = '0;
        endcase
    end

    assign writes_rf = ex_instr.opcode inside {ADDU, SUBU, AND, OR, SLT, MOV, JALR};
    assign rf_busy_o = writes_rf;
    assign halt_o    = (ex_instr.opcode == WAIT);

    // Branches test rd against zero
    assign taken = ((ex_instr.opcode == BEQZ) && (ex_rd == '0))
                || ((ex_instr.opcode == BNEQZ) && (ex_rd != '0));

    // Signed offset relative to the branch itself
    assign branch_pc = ex_pc + {{(IMEM_ADDR_W-RF_ADDR_W){ex_instr.rs_imm[RF_ADDR_W-1]}},
                                ex_instr.rs_imm};

    assign redirect_o = taken || (ex_instr.opcode == JALR) || halt_o;
    always_comb
    begin
        if (ex_instr.opcode == JALR)
            redirect_pc_o = ex_rs[IMEM_ADDR_W-1:0];
        else if (halt_o)
            redirect_pc_o = pc_plus1;
        else
            redirect_pc_o = branch_pc;
    end

    // Store strobe one cycle after SW commits
    always_ff @(posedge clk)
    begin
        if (!n_reset)
            store_valid_q <= 1'b0;
        else
            store_valid_q <= advance && (ex_instr.opcode == SW);
    end

    always_ff @(posedge clk)
    begin
        if (advance && (ex_instr.opcode == SW))
        begin
            store_addr_q <= ex_rd;
            store_data_q <= ex_rs;
        end
    end

    assign store_o = '{valid: store_valid_q, addr: store_addr_q, data: store_data_q};

endmodule

`default_nettype wire

// File: pipeline/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage
(
    input  wire                                 clk,
    input  wire                                 n_reset,
    input  wire core_pkg::ctrl_t                ctrl_i,
    input  wire logic [core_pkg::IMEM_ADDR_W-1:0] pc_load_addr_i,
    input  wire logic                           redirect_i,
    input  wire logic [core_pkg::IMEM_ADDR_W-1:0] redirect_pc_i,
    output logic [core_pkg::IMEM_ADDR_W-1:0]    imem_addr_o,
    input  wire core_pkg::instr_t               instr_i,
    output core_pkg::instr_t                    if_instr_o,
    output logic [core_pkg::IMEM_ADDR_W-1:0]    if_pc_o
);
    import core_pkg::*;

    logic [IMEM_ADDR_W-1:0] pc_q;
    logic [IMEM_ADDR_W-1:0] pc_n;
    logic                   advance;
    logic                   squash;
    logic                   refetch_q;

    assign advance = ctrl_i.run & ~ctrl_i.stall;

    // JALR or WAIT in decode, the next word is never wanted
    assign squash = (if_instr_o.opcode == JALR) || (if_instr_o.opcode == WAIT);

    // Next PC: network load, then execute redirect, then PC+1
    always_comb
    begin
        if (ctrl_i.pc_load)
            pc_n = pc_load_addr_i;
        else if (!advance)
            pc_n = pc_q;
        else if (redirect_i)
            pc_n = redirect_pc_i;
        else if (refetch_q)
            pc_n = pc_q;  // read data was the written word, fetch pc_q again
        else
            pc_n = pc_q + 1'b1;
    end

    // Memory is addressed with the next PC, one cycle read
    assign imem_addr_o = ctrl_i.imem_wr ? ctrl_i.pc_addr : pc_n;

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            pc_q       <= '0;
            if_instr_o <= INSTR_NOP;
            refetch_q  <= 1'b0;
        end
        else
        begin
            pc_q      <= pc_n;
            refetch_q <= ctrl_i.imem_wr;
            if (advance)
            begin
                if (redirect_i || squash || refetch_q)
                    if_instr_o <= INSTR_NOP;
                else
                    if_instr_o <= instr_i;
            end
        end
    end

    // PC of the fetched word
    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            if_pc_o <= pc_q;
        end
    end

endmodule

`default_nettype wire

// File: pipeline/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file
(
    input  wire                                 clk,
    input  wire logic [core_pkg::RF_ADDR_W-1:0] rs_addr_i,
    input  wire logic [core_pkg::RF_ADDR_W-1:0] rd_addr_i,
    input  wire logic                           wr_en_i,
    input  wire logic [core_pkg::RF_ADDR_W-1:0] wr_addr_i,
    input  wire logic [core_pkg::DATA_W-1:0]    wr_data_i,
    output logic [core_pkg::DATA_W-1:0]         rs_val_o,
    output logic [core_pkg::DATA_W-1:0]         rd_val_o
);
    import core_pkg::*;

    logic [DATA_W-1:0] regs [2**RF_ADDR_W];

    // Single write port, register 0 never written
    always_ff @(posedge clk)
    begin
        if (wr_en_i && (wr_addr_i != '0))
        begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // Combinational reads, register 0 is hardwired zero
    assign rs_val_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
    assign rd_val_o = (rd_addr_i == '0) ? '0 : regs[rd_addr_i];

endmodule

`default_nettype wire

// File: project.f
common/core_pkg.sv
src/instr_mem.sv
src/core_ctrl.sv
pipeline/fetch_stage.sv
pipeline/reg_file.sv
pipeline/exec_stage.sv
src/core_top.sv
sim/tb_clkgen.sv
sim/core_chk.sv
sim/tb_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_core -f project.f -o Vtb_core; then
    echo "Build failed"
    exit 1
fi

./obj_dir/Vtb_core > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi

echo "Simulation passed"
exit 0

// File: sim/core_chk.sv
`timescale 1ns/10ps
`default_nettype none

module core_chk
(
    input  wire                     clk,
    input  wire                     n_reset,
    input  wire logic               exception_i,
    input  wire core_pkg::store_t   store_i
);

    // Exception is sticky, only reset clears it
    exc_sticky: assert property (@(posedge clk)
        (n_reset && $past(n_reset)) |-> !$fell(exception_i))
        else $error("exception_o fell while out of reset");

    // Store strobe cleared by reset
    store_reset: assert property (@(posedge clk)
        !n_reset |=> !store_i.valid)
        else $error("store_o.valid high in the cycle after reset");

    // No unknown address or data on a valid store
    store_known: assert property (@(posedge clk) disable iff (!n_reset)
        store_i.valid |-> !$isunknown({store_i.addr, store_i.data}))
        else $error("store_o fields unknown while valid");

endmodule

bind core_top core_chk u_chk (
    .clk         (clk),
    .n_reset     (n_reset),
    .exception_i (exception_o),
    .store_i     (store_o)
);

`default_nettype wire

// File: sim/tb_clkgen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen
(
    output logic clk_o,
    output logic n_reset_o
);
    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 10;

    // 100 ns clock
    initial clk_o = 1'b0;
    always #HALF_PERIOD clk_o = ~clk_o;

    // Reset held for ten rising edges, released on a falling edge
    initial
    begin
        n_reset_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        n_reset_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/tb_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_core;
    import core_pkg::*;

    localparam logic [31:0] LFSR_SEED = 32'h9d16_0cdc;
    // Galois taps for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam int MAX_STEPS    = 256;
    localparam int QUIET_CYCLES = 20;
    // Program words per test in run order
    localparam int PROG_WORDS     = 13 + 8 + 18 + 13 + 3 + 5;
    localparam int TIMEOUT_CYCLES = 20 * PROG_WORDS + 50 * 6;

    logic        clk;
    logic        n_reset;
    net_packet_t net_packet;
    store_t      store;
    logic        exception;

    logic [31:0] lfsr_state;
    logic [31:0] model_regs [2**RF_ADDR_W];
    instr_t      model_imem [2**IMEM_ADDR_W];
    instr_t      prog_q [$];
    store_t      exp_q [$];
    store_t      exp_store;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          test_err_base;
    int          cycle_count = 0;

    tb_clkgen u_clkgen (
        .clk_o     (clk),
        .n_reset_o (n_reset)
    );

    core_top dut_i (
        .clk          (clk),
        .n_reset      (n_reset),
        .net_packet_i (net_packet),
        .store_o      (store),
        .exception_o  (exception)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? LFSR_TAPS : 32'h0);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Bit 1 is set so the ID never equals CORE_ID
    function automatic logic [NET_ID_W-1:0] foreign_id();
        logic [31:0] r;
        r = rand_bits(NET_ID_W);
        return r[NET_ID_W-1:0] | 10'h002;
    endfunction

    // ISA interpreter over the model program and registers that queues the expected stores
    function automatic int reference_run(input logic [IMEM_ADDR_W-1:0] start_pc);
        logic [IMEM_ADDR_W-1:0] pc;
        logic [IMEM_ADDR_W-1:0] pc_next;
        instr_t                 ins;
        logic [31:0]            rdv;
        logic [31:0]            rsv;
        logic [31:0]            result;
        logic                   wr;
        logic                   running;
        int                     steps;
        int                     count;
        store_t                 st;
        pc = start_pc;
        running = 1'b1;
        steps = 0;
        count = 0;
        while (running && (steps < MAX_STEPS))
        begin
            ins = model_imem[pc];
            rdv = model_regs[ins.rd];
            rsv = model_regs[ins.rs_imm];
            pc_next = pc + 10'd1;
            result = '0;
            wr = 1'b0;
            steps++;
            case (ins.opcode)
                ADDU:
                begin
                    result = rdv + rsv;
                    wr = 1'b1;
                end
                SUBU:
                begin
                    result = rdv - rsv;
                    wr = 1'b1;
                end
                AND:
                begin
                    result = rdv & rsv;
                    wr = 1'b1;
                end
                OR:
                begin
                    result = rdv | rsv;
                    wr = 1'b1;
                end
                SLT:
                begin
                    result = {31'b0, $signed(rdv) < $signed(rsv)};
                    wr = 1'b1;
                end
                MOV:
                begin
                    result = rsv;
                    wr = 1'b1;
                end
                // Offset counts from the branch itself
                BEQZ:  if (rdv == 0) pc_next = pc + {{5{ins.rs_imm[4]}}, ins.rs_imm};
                BNEQZ: if (rdv != 0) pc_next = pc + {{5{ins.rs_imm[4]}}, ins.rs_imm};
                JALR:
                begin
                    result = {22'b0, pc + 10'd1};
                    wr = 1'b1;
                    pc_next = rsv[IMEM_ADDR_W-1:0];
                end
                SW:
                begin
                    st = '{valid: 1'b1, addr: rdv, data: rsv};
                    exp_q.push_back(st);
                    count++;
                end
                WAIT:  running = 1'b0;
                default: ;
            endcase
            if (wr && (ins.rd != 0))
                model_regs[ins.rd] = result;
            pc = pc_next;
        end
        return count;
    endfunction

    // One packet for one cycle followed by an idle bus
    task automatic send_packet(input logic [NET_ID_W-1:0] id, input net_op_e op,
                               input logic [IMEM_ADDR_W-1:0] addr, input logic [31:0] data);
        @(negedge clk);
        net_packet = '{id: id, op: op, addr: addr, data: data};
        @(negedge clk);
        net_packet = '0;
    endtask

    task automatic write_reg(input int r, input logic [31:0] v);
        send_packet(CORE_ID, NET_REG, 10'(r), v);
        if (r != 0)
            model_regs[r] = v;
    endtask

    task automatic emit(input opcode_e op, input int rd, input int rs);
        instr_t ins;
        ins = '{opcode: op, rd: 5'(rd), rs_imm: 5'(rs)};
        prog_q.push_back(ins);
    endtask

    task automatic load_program(input int base);
        foreach (prog_q[i])
        begin
            send_packet(CORE_ID, NET_INSTR, 10'(base + i), {16'h0, prog_q[i]});
            model_imem[10'(base + i)] = prog_q[i];
        end
        prog_q.delete();
    endtask

    // Expected stores are queued before the core starts
    task automatic start_program(input int pc);
        void'(reference_run(10'(pc)));
        send_packet(CORE_ID, NET_PC, 10'(pc), 32'h0);
    endtask

    task automatic wait_stores(input int words);
        int waited;
        waited = 0;
        while ((exp_q.size() != 0) && (waited < 10 * words + 20))
        begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            $display("Missing stores: %0d expected stores never appeared", exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    // Room for the trailing WAIT and for any extra store to show
    task automatic quiet_window();
        repeat (QUIET_CYCLES) @(negedge clk);
    endtask

    task automatic report_test(input int num, input string name);
        tests_run++;
        if (errors == test_err_base)
            $display("Test %0d %s: passed", num, name);
        else
        begin
            tests_failed++;
            $display("Test %0d %s: FAILED, %0d errors", num, name, errors - test_err_base);
        end
        test_err_base = errors;
    endtask

    // Stores compared on the falling edge where outputs have settled
    always @(negedge clk)
    begin
        if (n_reset && store.valid)
        begin
            if (exp_q.size() == 0)
            begin
                $display("Unexpected store at %0d ns: addr %h data %h was not expected",
                         $time, store.addr, store.data);
                errors++;
            end
            else
            begin
                exp_store = exp_q.pop_front();
                checks++;
                if ((store.addr !== exp_store.addr) || (store.data !== exp_store.data))
                begin
                    $display("ERROR at %0d ns: store addr %h data %h, expected addr %h data %h",
                             $time, store.addr, store.data, exp_store.addr, exp_store.data);
                    errors++;
                end
            end
        end
    end

    // Watchdog
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    initial
    begin
        int waited;
        net_packet = '0;
        lfsr_state = LFSR_SEED;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        test_err_base = 0;
        for (int i = 0; i < 2**RF_ADDR_W; i++)
            model_regs[i] = '0;
        while (n_reset !== 1'b1)
            @(negedge clk);

        // ALU ops then a block of stores
        for (int i = 1; i < 2**RF_ADDR_W; i++)
            write_reg(i, rand_bits(32));
        emit(ADDU, 1, 2);
        emit(SUBU, 3, 4);
        emit(AND, 5, 6);
        emit(OR, 7, 8);
        emit(SLT, 9, 10);
        emit(MOV, 11, 12);
        emit(SW, 13, 1);
        emit(SW, 13, 3);
        emit(SW, 14, 5);
        emit(SW, 14, 7);
        emit(SW, 15, 9);
        emit(SW, 15, 11);
        emit(WAIT, 0, 0);
        load_program(0);
        start_program(0);
        wait_stores(13);
        quiet_window();
        report_test(1, "load and run");

        // Each op uses the previous result
        emit(ADDU, 16, 17);
        emit(SUBU, 16, 18);
        emit(MOV, 19, 16);
        emit(OR, 19, 20);
        emit(ADDU, 21, 19);
        emit(SW, 22, 21);
        emit(SW, 21, 19);
        emit(WAIT, 0, 0);
        load_program(32);
        start_program(32);
        wait_stores(8);
        quiet_window();
        report_test(2, "bypass");

        // r23 zero, r24 nonzero, r25 holds the JALR target
        write_reg(23, 32'h0);
        write_reg(24, rand_bits(32) | 32'h1);
        write_reg(25, 32'd80);
        emit(BEQZ, 24, 3);
        emit(SW, 26, 24);
        emit(BEQZ, 23, 3);
        emit(SW, 26, 23);
        emit(SW, 26, 26);
        emit(BNEQZ, 23, 2);
        emit(BNEQZ, 24, 3);
        emit(SW, 27, 27);
        emit(WAIT, 0, 0);
        emit(JALR, 28, 25);
        emit(SW, 27, 27);
        emit(WAIT, 0, 0);
        emit(SW, 26, 27);
        emit(SW, 27, 24);
        emit(WAIT, 0, 0);
        emit(SW, 27, 26);
        emit(SW, 26, 28);
        emit(BEQZ, 23, -4);
        load_program(64);
        start_program(64);
        wait_stores(18);
        quiet_window();
        report_test(3, "control flow");

        // New operands for the first program
        for (int i = 1; i < 16; i++)
            write_reg(i, rand_bits(32));
        start_program(0);
        wait_stores(13);
        quiet_window();
        report_test(4, "restart");

        // Foreign packets would stop the store or start the core early
        emit(ADDU, 29, 30);
        emit(SW, 31, 29);
        emit(WAIT, 0, 0);
        load_program(96);
        write_reg(29, rand_bits(32));
        write_reg(30, rand_bits(32));
        write_reg(31, rand_bits(32));
        send_packet(foreign_id(), NET_INSTR, 10'd96, {16'h0, WAIT, 10'h0});
        send_packet(foreign_id(), NET_REG, 10'd29, rand_bits(32));
        send_packet(foreign_id(), NET_REG, 10'd31, rand_bits(32));
        send_packet(foreign_id(), NET_PC, 10'd96, 32'h0);
        quiet_window();
        start_program(96);
        send_packet(foreign_id(), NET_PC, 10'd0, 32'h0);
        wait_stores(3);
        quiet_window();
        checks++;
        if (exception !== 1'b0)
        begin
            $display("Exception raised by a packet for another core");
            errors++;
        end
        report_test(6, "ID filter");

        // One store, a short countdown on r2, then a second store
        write_reg(2, 32'd3);
        write_reg(3, 32'd1);
        emit(SW, 31, 30);
        emit(SUBU, 2, 3);
        emit(BNEQZ, 2, -1);
        emit(SW, 31, 29);
        emit(WAIT, 0, 0);
        load_program(112);
        start_program(112);
        waited = 0;
        while ((exp_q.size() > 1) && (waited < 50))
        begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() > 1)
        begin
            $display("Missing stores: the first store of the exception program never appeared");
            errors++;
        end
        // The bad PC command lands inside the countdown, so the second store never comes
        exp_q.delete();
        send_packet(CORE_ID, NET_PC, 10'd112, 32'h0);
        waited = 0;
        while ((exception !== 1'b1) && (waited < 10))
        begin
            @(negedge clk);
            waited++;
        end
        checks++;
        if (exception !== 1'b1)
        begin
            $display("Exception did not rise after a PC command while running");
            errors++;
        end
        quiet_window();
        checks++;
        if (exception !== 1'b1)
        begin
            $display("Exception dropped before reset");
            errors++;
        end
        report_test(5, "exception");

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/core_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module core_ctrl
(
    input  wire                         clk,
    input  wire                         n_reset,
    input  wire core_pkg::net_packet_t  net_packet_i,
    input  wire logic                   halt_i,
    input  wire logic                   rf_busy_i,
    output core_pkg::ctrl_t             ctrl_o,
    output logic                        exception_o
);
    import core_pkg::*;

    run_state_e state_r;
    run_state_e state_n;
    logic       id_match;
    logic       net_instr;
    logic       net_reg;
    logic       net_pc;
    logic       pc_load;
    logic       stall;

    // Packet only counts for our ID and a real command
    assign id_match  = (net_packet_i.id == CORE_ID);
    assign net_instr = id_match && (net_packet_i.op == NET_INSTR);
    assign net_reg   = id_match && (net_packet_i.op == NET_REG);
    assign net_pc    = id_match && (net_packet_i.op == NET_PC);

    // PC load is only legal from IDLE
    assign pc_load = net_pc && (state_r == IDLE);

    // Hold pipeline when not running, on imem writes,
    // and on a register write port conflict with execute
    assign stall = (state_r != RUN) || net_instr || (net_reg && rf_busy_i);

    always_comb
    begin
        state_n = state_r;
        case (state_r)
            IDLE:
            begin
                if (pc_load)
                begin
                    state_n = RUN;
                end
            end
            RUN:
            begin
                // Bad PC command beats a retiring WAIT
                if (net_pc)
                begin
                    state_n = ERR;
                end
                else if (halt_i && !stall)
                begin
                    state_n = IDLE;
                end
            end
            default:
            begin
                // ERR only leaves through reset
                state_n = ERR;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            state_r     <= IDLE;
            exception_o <= 1'b0;
        end
        else
        begin
            state_r     <= state_n;
            // Sticky until reset
            exception_o <= exception_o | (net_pc && (state_r != IDLE));
        end
    end

    assign ctrl_o = '{
        imem_wr: net_instr,
        rf_wr:   net_reg,
        pc_load: pc_load,
        run:     (state_r == RUN),
        stall:   stall,
        rf_addr: net_packet_i.addr[RF_ADDR_W-1:0],
        pc_addr: net_packet_i.addr
    };

endmodule

`default_nettype wire

// File: src/core_top.sv
`timescale 1ns/10ps
`default_nettype none

module core_top
(
    input  wire                         clk,
    input  wire                         n_reset,
    input  wire core_pkg::net_packet_t  net_packet_i,
    output core_pkg::store_t            store_o,
    output logic                        exception_o
);
    import core_pkg::*;

    ctrl_t                  ctrl;
    instr_t                 imem_rd_data;
    instr_t                 if_instr;
    logic [IMEM_ADDR_W-1:0] imem_addr;
    logic [IMEM_ADDR_W-1:0] if_pc;
    logic [IMEM_ADDR_W-1:0] redirect_pc;
    logic                   redirect;
    logic                   halt;
    logic                   rf_busy;

    core_ctrl u_ctrl (
        .clk          (clk),
        .n_reset      (n_reset),
        .net_packet_i (net_packet_i),
        .halt_i       (halt),
        .rf_busy_i    (rf_busy),
        .ctrl_o       (ctrl),
        .exception_o  (exception_o)
    );

    // Single shared address, the network address during writes
    instr_mem u_imem (
        .clk       (clk),
        .wr_en_i   (ctrl.imem_wr),
        .wr_addr_i (imem_addr),
        .wr_data_i (instr_t'(net_packet_i.data[$bits(instr_t)-1:0])),
        .rd_addr_i (imem_addr),
        .instr_o   (imem_rd_data)
    );

    fetch_stage u_fetch (
        .clk            (clk),
        .n_reset        (n_reset),
        .ctrl_i         (ctrl),
        .pc_load_addr_i (net_packet_i.addr),
        .redirect_i     (redirect),
        .redirect_pc_i  (redirect_pc),
        .imem_addr_o    (imem_addr),
        .instr_i        (imem_rd_data),
        .if_instr_o     (if_instr),
        .if_pc_o        (if_pc)
    );

    exec_stage u_exec (
        .clk           (clk),
        .n_reset       (n_reset),
        .ctrl_i        (ctrl),
        .net_packet_i  (net_packet_i),
        .if_instr_i    (if_instr),
        .if_pc_i       (if_pc),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .halt_o        (halt),
        .rf_busy_o     (rf_busy),
        .store_o       (store_o)
    );

endmodule

`default_nettype wire

// File: src/instr_mem.sv
`timescale 1ns/10ps
`default_nettype none

module instr_mem
(
    input  wire                                 clk,
    input  wire logic                           wr_en_i,
    input  wire logic [core_pkg::IMEM_ADDR_W-1:0] wr_addr_i,
    input  wire core_pkg::instr_t               wr_data_i,
    input  wire logic [core_pkg::IMEM_ADDR_W-1:0] rd_addr_i,
    output core_pkg::instr_t                    instr_o
);
    import core_pkg::*;

    // One instruction word per address, contents left uninitialized
    instr_t mem [2**IMEM_ADDR_W];

    always_ff @(posedge clk)
    begin
        if (wr_en_i)
        begin
            mem[wr_addr_i] <= wr_data_i;
        end
        // Registered read, old word on a same-address collision
        instr_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire
